/* hdl/tlb_pkg.sv */
package tlb_pkg;

  // Bus and page geometry
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int PAGE_W      = 12;
  localparam int PN_W        = ADDR_W - PAGE_W;
  localparam int NUM_ENTRIES = 4;
  localparam int IDX_W       = $clog2(NUM_ENTRIES);

  // Request buffer between lookup and forwarder
  localparam int FIFO_DEPTH = 2;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Configuration map, four words per entry
  localparam int         CFG_ENTRY_STRIDE = 16;
  localparam int         CFG_WORD_LSB     = 2;
  localparam int         CFG_IDX_LSB      = $clog2(CFG_ENTRY_STRIDE);
  localparam logic [1:0] CFG_FIRST_OFS    = 2'd0;
  localparam logic [1:0] CFG_LAST_OFS     = 2'd1;
  localparam logic [1:0] CFG_BASE_OFS     = 2'd2;
  localparam logic [1:0] CFG_FLAGS_OFS    = 2'd3;
  localparam int         CFG_VALID_BIT    = 0;
  localparam int         CFG_RO_BIT       = 1;

  typedef logic [1:0] resp_t;
  localparam resp_t             RESP_OKAY   = 2'b00;
  localparam resp_t             RESP_SLVERR = 2'b10;
  localparam logic [DATA_W-1:0] MISS_RDATA  = 32'hBADC0DE5;

  // One page-range mapping; last_pn is inclusive
  typedef struct packed {
    logic            valid;
    logic            read_only;
    logic [PN_W-1:0] first_pn;
    logic [PN_W-1:0] last_pn;
    logic [PN_W-1:0] base_pn;
  } tlb_entry_t;

  // Looked-up request; addr is translated on a hit, original on a miss
  typedef struct packed {
    logic              is_write;
    logic              hit;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } tlb_req_t;

endpackage

/* hdl/tlb_req_if.sv */
`timescale 1ns/10ps

interface tlb_req_if import tlb_pkg::*; ();

  logic     valid;
  logic     ready;
  tlb_req_t req;

  // Producer side
  modport push (
    output valid,
    output req,
    input  ready
  );

  // Consumer side
  modport pop (
    input  valid,
    input  req,
    output ready
  );

endinterface

/* hdl/tlb_cfg_regs.sv */
`timescale 1ns/10ps

module tlb_cfg_regs import tlb_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [ADDR_W-1:0] cfg_awaddr_i,
  input  logic              cfg_awvalid_i,
  output logic              cfg_awready_o,
  input  logic [DATA_W-1:0] cfg_wdata_i,
  input  logic [STRB_W-1:0] cfg_wstrb_i,
  input  logic              cfg_wvalid_i,
  output logic              cfg_wready_o,
  output resp_t             cfg_bresp_o,
  output logic              cfg_bvalid_o,
  input  logic              cfg_bready_i,
  input  logic [ADDR_W-1:0] cfg_araddr_i,
  input  logic              cfg_arvalid_i,
  output logic              cfg_arready_o,
  output logic [DATA_W-1:0] cfg_rdata_o,
  output resp_t             cfg_rresp_o,
  output logic              cfg_rvalid_o,
  input  logic              cfg_rready_i,
  output tlb_entry_t        entries_o [NUM_ENTRIES]
);

  tlb_entry_t        entries_q [NUM_ENTRIES];
  logic              accept_en_q;
  logic              b_valid_q;
  logic              r_valid_q;
  resp_t             b_resp_q;
  resp_t             r_resp_q;
  logic [DATA_W-1:0] r_data_q;
  logic              wr_hs;
  logic              rd_hs;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;
  logic [1:0]        wr_word;
  logic [1:0]        rd_word;
  logic [DATA_W-1:0] wr_old;
  logic [DATA_W-1:0] wr_merged;

  // Anything above the last entry is outside the map
  function automatic logic in_map(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1:CFG_IDX_LSB+IDX_W] == '0;
  endfunction

  function automatic logic [DATA_W-1:0] entry_word(input tlb_entry_t e, input logic [1:0] sel);
    logic [DATA_W-1:0] w;
    w = '0;
    case (sel)
      CFG_FIRST_OFS: w[PN_W-1:0] = e.first_pn;
      CFG_LAST_OFS:  w[PN_W-1:0] = e.last_pn;
      CFG_BASE_OFS:  w[PN_W-1:0] = e.base_pn;
      default: begin
        w[CFG_VALID_BIT] = e.valid;
        w[CFG_RO_BIT]    = e.read_only;
      end
    endcase
    return w;
  endfunction

  assign wr_idx  = cfg_awaddr_i[CFG_IDX_LSB +: IDX_W];
  assign rd_idx  = cfg_araddr_i[CFG_IDX_LSB +: IDX_W];
  assign wr_word = cfg_awaddr_i[CFG_WORD_LSB +: 2];
  assign rd_word = cfg_araddr_i[CFG_WORD_LSB +: 2];

  // Accept AW and W together, one write in flight
  assign wr_hs         = cfg_awvalid_i & cfg_wvalid_i & ~b_valid_q & accept_en_q;
  assign cfg_awready_o = wr_hs;
  assign cfg_wready_o  = wr_hs;
  assign rd_hs         = cfg_arvalid_i & ~r_valid_q & accept_en_q;
  assign cfg_arready_o = rd_hs;

  // Byte-lane merge of the new data into the current field value
  assign wr_old = entry_word(entries_q[wr_idx], wr_word);
  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      wr_merged[8*b +: 8] = cfg_wstrb_i[b] ? cfg_wdata_i[8*b +: 8] : wr_old[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      accept_en_q <= 1'b0;
      b_valid_q   <= 1'b0;
      r_valid_q   <= 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        entries_q[i] <= '0;
      end
    end else begin
      accept_en_q <= 1'b1;
      if (wr_hs) begin
        b_valid_q <= 1'b1;
        if (in_map(cfg_awaddr_i)) begin
          case (wr_word)
            CFG_FIRST_OFS: entries_q[wr_idx].first_pn <= wr_merged[PN_W-1:0];
            CFG_LAST_OFS:  entries_q[wr_idx].last_pn  <= wr_merged[PN_W-1:0];
            CFG_BASE_OFS:  entries_q[wr_idx].base_pn  <= wr_merged[PN_W-1:0];
            default: begin
              entries_q[wr_idx].valid     <= wr_merged[CFG_VALID_BIT];
              entries_q[wr_idx].read_only <= wr_merged[CFG_RO_BIT];
            end
          endcase
        end
      end else if (cfg_bready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (cfg_rready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payloads
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      b_resp_q <= in_map(cfg_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      r_resp_q <= in_map(cfg_araddr_i) ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= in_map(cfg_araddr_i) ? entry_word(entries_q[rd_idx], rd_word) : '0;
    end
  end

  assign cfg_bvalid_o = b_valid_q;
  assign cfg_bresp_o  = b_resp_q;
  assign cfg_rvalid_o = r_valid_q;
  assign cfg_rresp_o  = r_resp_q;
  assign cfg_rdata_o  = r_data_q;
  assign entries_o    = entries_q;

endmodule

/* hdl/tlb_lookup.sv */
`timescale 1ns/10ps

module tlb_lookup import tlb_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [ADDR_W-1:0] slv_awaddr_i,
  input  logic              slv_awvalid_i,
  output logic              slv_awready_o,
  input  logic [DATA_W-1:0] slv_wdata_i,
  input  logic [STRB_W-1:0] slv_wstrb_i,
  input  logic              slv_wvalid_i,
  output logic              slv_wready_o,
  input  logic [ADDR_W-1:0] slv_araddr_i,
  input  logic              slv_arvalid_i,
  output logic              slv_arready_o,
  input  tlb_entry_t        entries_i [NUM_ENTRIES],
  tlb_req_if.push           req_o
);

  logic                   prio_rd_q;
  logic                   wr_req;
  logic                   rd_req;
  logic                   sel_write;
  logic [ADDR_W-1:0]      in_addr;
  logic [PN_W-1:0]        in_pn;
  logic [PN_W-1:0]        xlat_pn;
  logic [NUM_ENTRIES-1:0] match;
  logic [IDX_W-1:0]       hit_idx;
  logic                   hit;
  tlb_req_t               req;

  // A write needs both AW and W present
  assign wr_req    = slv_awvalid_i & slv_wvalid_i;
  assign rd_req    = slv_arvalid_i;
  assign sel_write = wr_req & (~rd_req | ~prio_rd_q);

  assign in_addr = sel_write ? slv_awaddr_i : slv_araddr_i;
  assign in_pn   = in_addr[ADDR_W-1:PAGE_W];

  // Parallel range compare, lowest index wins
  always_comb begin
    hit_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      match[i] = entries_i[i].valid &&
                 in_pn >= entries_i[i].first_pn &&
                 in_pn <= entries_i[i].last_pn &&
                 !(sel_write && entries_i[i].read_only);
      if (match[i]) begin
        hit_idx = IDX_W'(i);
      end
    end
  end

  assign hit     = |match;
  assign xlat_pn = entries_i[hit_idx].base_pn + (in_pn - entries_i[hit_idx].first_pn);

  always_comb begin
    req.is_write = sel_write;
    req.hit      = hit;
    req.addr     = hit ? {xlat_pn, in_addr[PAGE_W-1:0]} : in_addr;
    req.wdata    = slv_wdata_i;
    req.wstrb    = slv_wstrb_i;
  end

  // Offered only when the FIFO can take it, so every valid cycle is a transfer
  assign req_o.valid   = (wr_req | rd_req) & req_o.ready;
  assign req_o.req     = req;
  assign slv_awready_o = req_o.ready & sel_write;
  assign slv_wready_o  = req_o.ready & sel_write;
  assign slv_arready_o = req_o.ready & rd_req & ~sel_write;

  // The other direction gets priority after each accepted request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_rd_q <= 1'b0;
    end else if (req_o.valid) begin
      prio_rd_q <= sel_write;
    end
  end

endmodule

/* hdl/tlb_req_fifo.sv */
`timescale 1ns/10ps

module tlb_req_fifo import tlb_pkg::*; (
  input  logic   clk_i,
  input  logic   reset_i,
  tlb_req_if.pop in_i,
  tlb_req_if.push out_o
);

  tlb_req_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  ready_en_q;
  logic                  full;
  logic                  push;
  logic                  pop;

  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    return (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count_q == FIFO_CNT_W'(FIFO_DEPTH));

  // Full FIFO still accepts when the head leaves on the same edge
  assign in_i.ready  = ready_en_q & (~full | out_o.ready);
  assign out_o.valid = (count_q != '0);
  assign out_o.req   = mem[rd_ptr_q];

  assign push = in_i.valid & in_i.ready;
  assign pop  = out_o.valid & out_o.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_i.req;
    end
  end

endmodule

/* hdl/tlb_forward.sv */
`timescale 1ns/10ps

module tlb_forward import tlb_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  tlb_req_if.pop            req_i,
  output logic [ADDR_W-1:0] mst_awaddr_o,
  output logic              mst_awvalid_o,
  input  logic              mst_awready_i,
  output logic [DATA_W-1:0] mst_wdata_o,
  output logic [STRB_W-1:0] mst_wstrb_o,
  output logic              mst_wvalid_o,
  input  logic              mst_wready_i,
  input  resp_t             mst_bresp_i,
  input  logic              mst_bvalid_i,
  output logic              mst_bready_o,
  output logic [ADDR_W-1:0] mst_araddr_o,
  output logic              mst_arvalid_o,
  input  logic              mst_arready_i,
  input  logic [DATA_W-1:0] mst_rdata_i,
  input  resp_t             mst_rresp_i,
  input  logic              mst_rvalid_i,
  output logic              mst_rready_o,
  output resp_t             slv_bresp_o,
  output logic              slv_bvalid_o,
  input  logic              slv_bready_i,
  output logic [DATA_W-1:0] slv_rdata_o,
  output resp_t             slv_rresp_o,
  output logic              slv_rvalid_o,
  input  logic              slv_rready_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_WAIT,
    S_RESP
  } state_e;

  state_e            state_q;
  tlb_req_t          cur_q;
  logic              aw_valid_q;
  logic              w_valid_q;
  logic              ar_valid_q;
  logic              b_valid_q;
  logic              r_valid_q;
  resp_t             b_resp_q;
  resp_t             r_resp_q;
  logic [DATA_W-1:0] r_data_q;
  logic              pop;
  logic              aw_left;
  logic              w_left;
  logic              ar_left;
  logic              b_hs;
  logic              r_hs;

  assign req_i.ready = (state_q == S_IDLE);
  assign pop         = req_i.valid & req_i.ready;

  // Channels still waiting for their handshake
  assign aw_left = aw_valid_q & ~mst_awready_i;
  assign w_left  = w_valid_q & ~mst_wready_i;
  assign ar_left = ar_valid_q & ~mst_arready_i;

  assign mst_bready_o = (state_q == S_WAIT) & cur_q.is_write;
  assign mst_rready_o = (state_q == S_WAIT) & ~cur_q.is_write;
  assign b_hs         = mst_bvalid_i & mst_bready_o;
  assign r_hs         = mst_rvalid_i & mst_rready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= S_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      ar_valid_q <= 1'b0;
      b_valid_q  <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (pop && req_i.req.hit) begin
            aw_valid_q <= req_i.req.is_write;
            w_valid_q  <= req_i.req.is_write;
            ar_valid_q <= ~req_i.req.is_write;
            state_q    <= S_ADDR;
          end else if (pop) begin
            // Miss goes straight back as an error
            b_valid_q <= req_i.req.is_write;
            r_valid_q <= ~req_i.req.is_write;
            state_q   <= S_RESP;
          end
        end
        S_ADDR: begin
          aw_valid_q <= aw_left;
          w_valid_q  <= w_left;
          ar_valid_q <= ar_left;
          if (!(aw_left || w_left || ar_left)) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (b_hs || r_hs) begin
            b_valid_q <= b_hs;
            r_valid_q <= r_hs;
            state_q   <= S_RESP;
          end
        end
        default: begin
          if ((b_valid_q && slv_bready_i) || (r_valid_q && slv_rready_i)) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            state_q   <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Request and response payloads; error values preloaded for misses
  always_ff @(posedge clk_i) begin
    if (pop) begin
      cur_q    <= req_i.req;
      b_resp_q <= RESP_SLVERR;
      r_resp_q <= RESP_SLVERR;
      r_data_q <= MISS_RDATA;
    end
    if (b_hs) begin
      b_resp_q <= mst_bresp_i;
    end
    if (r_hs) begin
      r_resp_q <= mst_rresp_i;
      r_data_q <= mst_rdata_i;
    end
  end

  assign mst_awaddr_o  = cur_q.addr;
  assign mst_awvalid_o = aw_valid_q;
  assign mst_wdata_o   = cur_q.wdata;
  assign mst_wstrb_o   = cur_q.wstrb;
  assign mst_wvalid_o  = w_valid_q;
  assign mst_araddr_o  = cur_q.addr;
  assign mst_arvalid_o = ar_valid_q;
  assign slv_bresp_o   = b_resp_q;
  assign slv_bvalid_o  = b_valid_q;
  assign slv_rdata_o   = r_data_q;
  assign slv_rresp_o   = r_resp_q;
  assign slv_rvalid_o  = r_valid_q;

endmodule

/* hdl/axi_tlb.sv */
`timescale 1ns/10ps

module axi_tlb import tlb_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  // Main subordinate port
  input  logic [ADDR_W-1:0] slv_awaddr_i,
  input  logic              slv_awvalid_i,
  output logic              slv_awready_o,
  input  logic [DATA_W-1:0] slv_wdata_i,
  input  logic [STRB_W-1:0] slv_wstrb_i,
  input  logic              slv_wvalid_i,
  output logic              slv_wready_o,
  output resp_t             slv_bresp_o,
  output logic              slv_bvalid_o,
  input  logic              slv_bready_i,
  input  logic [ADDR_W-1:0] slv_araddr_i,
  input  logic              slv_arvalid_i,
  output logic              slv_arready_o,
  output logic [DATA_W-1:0] slv_rdata_o,
  output resp_t             slv_rresp_o,
  output logic              slv_rvalid_o,
  input  logic              slv_rready_i,
  // Main manager port
  output logic [ADDR_W-1:0] mst_awaddr_o,
  output logic              mst_awvalid_o,
  input  logic              mst_awready_i,
  output logic [DATA_W-1:0] mst_wdata_o,
  output logic [STRB_W-1:0] mst_wstrb_o,
  output logic              mst_wvalid_o,
  input  logic              mst_wready_i,
  input  resp_t             mst_bresp_i,
  input  logic              mst_bvalid_i,
  output logic              mst_bready_o,
  output logic [ADDR_W-1:0] mst_araddr_o,
  output logic              mst_arvalid_o,
  input  logic              mst_arready_i,
  input  logic [DATA_W-1:0] mst_rdata_i,
  input  resp_t             mst_rresp_i,
  input  logic              mst_rvalid_i,
  output logic              mst_rready_o,
  // Configuration port
  input  logic [ADDR_W-1:0] cfg_awaddr_i,
  input  logic              cfg_awvalid_i,
  output logic              cfg_awready_o,
  input  logic [DATA_W-1:0] cfg_wdata_i,
  input  logic [STRB_W-1:0] cfg_wstrb_i,
  input  logic              cfg_wvalid_i,
  output logic              cfg_wready_o,
  output resp_t             cfg_bresp_o,
  output logic              cfg_bvalid_o,
  input  logic              cfg_bready_i,
  input  logic [ADDR_W-1:0] cfg_araddr_i,
  input  logic              cfg_arvalid_i,
  output logic              cfg_arready_o,
  output logic [DATA_W-1:0] cfg_rdata_o,
  output resp_t             cfg_rresp_o,
  output logic              cfg_rvalid_o,
  input  logic              cfg_rready_i
);

  tlb_entry_t entries [NUM_ENTRIES];

  // Lookup results into the FIFO, FIFO head into the forwarder
  tlb_req_if lookup_req ();
  tlb_req_if fwd_req ();

  tlb_cfg_regs u_cfg (
    .*,
    .entries_o (entries)
  );

  tlb_lookup u_lookup (
    .*,
    .entries_i (entries),
    .req_o     (lookup_req)
  );

  tlb_req_fifo u_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_i    (lookup_req),
    .out_o   (fwd_req)
  );

  tlb_forward u_forward (
    .*,
    .req_i (fwd_req)
  );

endmodule

/* dv/tb_axi_tlb_assertions.sv */
`timescale 1ns/10ps

module tb_axi_tlb_assertions (
  input logic        clk_i,
  input logic        reset_i,
  input logic [31:0] mst_awaddr_o,
  input logic        mst_awvalid_o,
  input logic        mst_awready_i,
  input logic [31:0] mst_wdata_o,
  input logic [3:0]  mst_wstrb_o,
  input logic        mst_wvalid_o,
  input logic        mst_wready_i,
  input logic [31:0] mst_araddr_o,
  input logic        mst_arvalid_o,
  input logic        mst_arready_i,
  input logic [1:0]  slv_bresp_o,
  input logic        slv_bvalid_o,
  input logic        slv_bready_i,
  input logic [31:0] slv_rdata_o,
  input logic [1:0]  slv_rresp_o,
  input logic        slv_rvalid_o,
  input logic        slv_rready_i,
  input logic        cfg_bvalid_o,
  input logic        cfg_rvalid_o
);

  // Valid held with stable payload until accepted
  a_aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_awvalid_o && !mst_awready_i |=> mst_awvalid_o && $stable(mst_awaddr_o))
    else $error("mst AW dropped or changed before ready");
  a_w_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_wvalid_o && !mst_wready_i |=> mst_wvalid_o && $stable({mst_wdata_o, mst_wstrb_o}))
    else $error("mst W dropped or changed before ready");
  a_ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_arvalid_o && !mst_arready_i |=> mst_arvalid_o && $stable(mst_araddr_o))
    else $error("mst AR dropped or changed before ready");
  a_b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_bvalid_o && !slv_bready_i |=> slv_bvalid_o && $stable(slv_bresp_o))
    else $error("slv B dropped or changed before ready");
  a_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_rvalid_o && !slv_rready_i |=> slv_rvalid_o && $stable({slv_rdata_o, slv_rresp_o}))
    else $error("slv R dropped or changed before ready");

  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> !(mst_awvalid_o || mst_wvalid_o || mst_arvalid_o ||
                                     slv_bvalid_o || slv_rvalid_o || cfg_bvalid_o ||
                                     cfg_rvalid_o))
    else $error("valid output high during reset");

  // One outstanding transaction on the manager port
  a_one_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    !(mst_awvalid_o && mst_arvalid_o))
    else $error("mst AW and AR valid together");

endmodule

bind axi_tlb tb_axi_tlb_assertions u_assert (.*);

/* dv/tb_axi_tlb.sv */
`timescale 1ns/10ps

module tb_axi_tlb import tlb_pkg::*; ();

  // Expected subordinate-side response
  typedef struct packed {
    logic              is_write;
    resp_t             resp;
    logic [DATA_W-1:0] data;
  } rsp_t;

  logic clk_i, reset_i;
  logic [ADDR_W-1:0] slv_awaddr_i, slv_araddr_i, mst_awaddr_o, mst_araddr_o;
  logic [ADDR_W-1:0] cfg_awaddr_i, cfg_araddr_i;
  logic [DATA_W-1:0] slv_wdata_i, slv_rdata_o, mst_wdata_o, mst_rdata_i;
  logic [DATA_W-1:0] cfg_wdata_i, cfg_rdata_o;
  logic [STRB_W-1:0] slv_wstrb_i, mst_wstrb_o, cfg_wstrb_i;
  logic slv_awvalid_i, slv_awready_o, slv_wvalid_i, slv_wready_o, slv_bvalid_o, slv_bready_i;
  logic slv_arvalid_i, slv_arready_o, slv_rvalid_o, slv_rready_i;
  logic mst_awvalid_o, mst_awready_i, mst_wvalid_o, mst_wready_i, mst_bvalid_i, mst_bready_o;
  logic mst_arvalid_o, mst_arready_i, mst_rvalid_i, mst_rready_o;
  logic cfg_awvalid_i, cfg_awready_o, cfg_wvalid_i, cfg_wready_o, cfg_bvalid_o, cfg_bready_i;
  logic cfg_arvalid_i, cfg_arready_o, cfg_rvalid_o, cfg_rready_i;
  resp_t slv_bresp_o, slv_rresp_o, mst_bresp_i, mst_rresp_i, cfg_bresp_o, cfg_rresp_o;

  tlb_entry_t tbl [NUM_ENTRIES];
  tlb_req_t   exp_mst [$];
  rsp_t       exp_rsp [$];
  logic       bp_en;
  int         cycles;

  axi_tlb u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1);
  endtask

  // About 300 accesses at up to 30 cycles each, plus configuration
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 20000) begin
      stop_run("Simulation timed out before all responses arrived");
    end
  end

  // Lowest matching entry translates; page sum wraps at PN_W bits
  function automatic logic model_lookup(input logic [ADDR_W-1:0] addr, input logic wr,
                                        output logic [ADDR_W-1:0] xaddr);
    logic [PN_W-1:0] pn;
    pn = addr[ADDR_W-1:PAGE_W];
    xaddr = addr;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl[i].valid && pn >= tbl[i].first_pn && pn <= tbl[i].last_pn &&
          !(wr && tbl[i].read_only)) begin
        xaddr = {PN_W'(tbl[i].base_pn + (pn - tbl[i].first_pn)), addr[PAGE_W-1:0]};
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic record_req(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
    logic [ADDR_W-1:0] xaddr;
    logic              hit;
    rsp_t              r;
    hit = model_lookup(addr, wr, xaddr);
    if (hit) begin
      exp_mst.push_back('{is_write: wr, hit: 1'b1, addr: xaddr, wdata: wdata, wstrb: wstrb});
    end
    r.is_write = wr;
    if (!hit) begin
      r.resp = RESP_SLVERR;
      r.data = MISS_RDATA;
    end else if (wr) begin
      r.resp = xaddr[2] ? RESP_SLVERR : RESP_OKAY;
      r.data = '0;
    end else begin
      r.resp = RESP_OKAY;
      r.data = xaddr ^ 32'h5A5A5A5A;
    end
    exp_rsp.push_back(r);
  endtask

  // Main-port handshakes and responses, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (slv_wready_o == slv_awready_o)
        else stop_run($sformatf("FAIL %0t: slv AW and W ready differ", $time));
      if (slv_awvalid_i && slv_awready_o) begin
        record_req(1'b1, slv_awaddr_i, slv_wdata_i, slv_wstrb_i);
      end
      if (slv_arvalid_i && slv_arready_o) begin
        record_req(1'b0, slv_araddr_i, '0, '0);
      end
      if (slv_bvalid_o && slv_bready_i) begin
        assert (exp_rsp.size() > 0 && exp_rsp[0].is_write && slv_bresp_o == exp_rsp[0].resp)
          else stop_run($sformatf("FAIL %0t: unexpected B resp %0d", $time, slv_bresp_o));
        void'(exp_rsp.pop_front());
      end
      if (slv_rvalid_o && slv_rready_i) begin
        assert (exp_rsp.size() > 0 && !exp_rsp[0].is_write &&
                slv_rresp_o == exp_rsp[0].resp && slv_rdata_o == exp_rsp[0].data)
          else stop_run($sformatf("FAIL %0t: unexpected R %h resp %0d", $time,
                                  slv_rdata_o, slv_rresp_o));
        void'(exp_rsp.pop_front());
      end
    end
  end

  // Manager-side write responder
  task automatic serve_writes();
    tlb_req_t cur;
    forever begin
      do @(negedge clk_i); while (!mst_awvalid_o);
      repeat ($urandom % 4) @(posedge clk_i);
      @(posedge clk_i);
      #1 mst_awready_i = 1'b1;
      @(negedge clk_i);
      assert (exp_mst.size() > 0 && exp_mst[0].is_write && mst_awaddr_o == exp_mst[0].addr)
        else stop_run($sformatf("FAIL %0t: unexpected mst AW addr %h", $time, mst_awaddr_o));
      cur = exp_mst.pop_front();
      @(posedge clk_i);
      #1 mst_awready_i = 1'b0;
      do @(negedge clk_i); while (!mst_wvalid_o);
      repeat ($urandom % 4) @(posedge clk_i);
      @(posedge clk_i);
      #1 mst_wready_i = 1'b1;
      @(negedge clk_i);
      assert (mst_wdata_o == cur.wdata && mst_wstrb_o == cur.wstrb)
        else stop_run($sformatf("FAIL %0t: mst W %h/%h wrong", $time, mst_wdata_o, mst_wstrb_o));
      @(posedge clk_i);
      #1 mst_wready_i = 1'b0;
      mst_bvalid_i = 1'b1;
      mst_bresp_i  = cur.addr[2] ? RESP_SLVERR : RESP_OKAY;
      do @(negedge clk_i); while (!mst_bready_o);
      @(posedge clk_i);
      #1 mst_bvalid_i = 1'b0;
    end
  endtask

  // Manager-side read responder
  task automatic serve_reads();
    forever begin
      do @(negedge clk_i); while (!mst_arvalid_o);
      repeat ($urandom % 4) @(posedge clk_i);
      @(posedge clk_i);
      #1 mst_arready_i = 1'b1;
      @(negedge clk_i);
      assert (exp_mst.size() > 0 && !exp_mst[0].is_write && mst_araddr_o == exp_mst[0].addr)
        else stop_run($sformatf("FAIL %0t: unexpected mst AR addr %h", $time, mst_araddr_o));
      void'(exp_mst.pop_front());
      @(posedge clk_i);
      #1 mst_arready_i = 1'b0;
      mst_rvalid_i = 1'b1;
      mst_rresp_i  = RESP_OKAY;
      mst_rdata_i  = mst_araddr_o ^ 32'h5A5A5A5A;
      do @(negedge clk_i); while (!mst_rready_o);
      @(posedge clk_i);
      #1 mst_rvalid_i = 1'b0;
    end
  endtask

  task automatic toggle_ready();
    forever begin
      @(posedge clk_i);
      #1 slv_bready_i = bp_en ? (($urandom % 3) == 0) : 1'b1;
      slv_rready_i = bp_en ? (($urandom % 3) == 0) : 1'b1;
    end
  endtask

  task automatic random_access();
    logic [ADDR_W-1:0] addr;
    addr = {PN_W'($urandom % 'h68), PAGE_W'($urandom)};
    @(posedge clk_i);
    #1;
    if ($urandom % 2) begin
      slv_awaddr_i  = addr;
      slv_wdata_i   = $urandom;
      slv_wstrb_i   = STRB_W'($urandom);
      slv_awvalid_i = 1'b1;
      slv_wvalid_i  = 1'b1;
      do @(negedge clk_i); while (!slv_awready_o);
    end else begin
      slv_araddr_i  = addr;
      slv_arvalid_i = 1'b1;
      do @(negedge clk_i); while (!slv_arready_o);
    end
    @(posedge clk_i);
    #1 slv_awvalid_i = 1'b0;
    slv_wvalid_i  = 1'b0;
    slv_arvalid_i = 1'b0;
  endtask

  task automatic cfg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input resp_t resp);
    @(posedge clk_i);
    #1 cfg_awaddr_i = addr;
    cfg_wdata_i   = data;
    cfg_awvalid_i = 1'b1;
    cfg_wvalid_i  = 1'b1;
    do @(negedge clk_i); while (!cfg_awready_o);
    assert (cfg_wready_o)
      else stop_run($sformatf("FAIL %0t: cfg W ready low with AW ready at %h", $time, addr));
    @(posedge clk_i);
    #1 cfg_awvalid_i = 1'b0;
    cfg_wvalid_i  = 1'b0;
    do @(negedge clk_i); while (!cfg_bvalid_o);
    assert (cfg_bresp_o == resp)
      else stop_run($sformatf("FAIL %0t: cfg B resp %0d at %h", $time, cfg_bresp_o, addr));
  endtask

  task automatic cfg_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input resp_t resp);
    @(posedge clk_i);
    #1 cfg_araddr_i = addr;
    cfg_arvalid_i = 1'b1;
    do @(negedge clk_i); while (!cfg_arready_o);
    @(posedge clk_i);
    #1 cfg_arvalid_i = 1'b0;
    do @(negedge clk_i); while (!cfg_rvalid_o);
    assert (cfg_rresp_o == resp && cfg_rdata_o == data)
      else stop_run($sformatf("FAIL %0t: cfg read %h gave %h", $time, addr, cfg_rdata_o));
  endtask

  // Upper junk bits must be dropped by the field width
  task automatic set_entry(input int idx, input logic [PN_W-1:0] first, input logic [PN_W-1:0] last,
                           input logic [PN_W-1:0] base, input logic [1:0] flags);
    logic [ADDR_W-1:0] a;
    a = ADDR_W'(idx * CFG_ENTRY_STRIDE);
    cfg_write(a, 32'hFFF00000 | first, RESP_OKAY);
    cfg_write(a + 4, 32'hFFF00000 | last, RESP_OKAY);
    cfg_write(a + 8, 32'hFFF00000 | base, RESP_OKAY);
    cfg_write(a + 12, 32'hFFFFFFFC | flags, RESP_OKAY);
    tbl[idx] = '{valid: flags[0], read_only: flags[1], first_pn: first, last_pn: last,
                 base_pn: base};
    cfg_read(a, 32'(first), RESP_OKAY);
    cfg_read(a + 4, 32'(last), RESP_OKAY);
    cfg_read(a + 8, 32'(base), RESP_OKAY);
    cfg_read(a + 12, 32'(flags), RESP_OKAY);
  endtask

  task automatic drain();
    while (exp_rsp.size() != 0 || exp_mst.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  initial begin
    void'($urandom(65253));
    {slv_awaddr_i, slv_araddr_i, slv_wdata_i, slv_wstrb_i} = '0;
    {slv_awvalid_i, slv_wvalid_i, slv_arvalid_i, slv_bready_i, slv_rready_i} = '0;
    {mst_awready_i, mst_wready_i, mst_bvalid_i, mst_arready_i, mst_rvalid_i} = '0;
    {mst_bresp_i, mst_rresp_i, mst_rdata_i} = '0;
    {cfg_awaddr_i, cfg_araddr_i, cfg_wdata_i, cfg_awvalid_i, cfg_wvalid_i, cfg_arvalid_i} = '0;
    cfg_wstrb_i  = '1;
    cfg_bready_i = 1'b1;
    cfg_rready_i = 1'b1;
    bp_en   = 1'b0;
    cycles  = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      tbl[i] = '0;
    end
    reset_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 reset_i = 1'b0;
    fork
      serve_writes();
      serve_reads();
      toggle_ready();
    join_none
    // Empty table, everything misses
    repeat (20) random_access();
    drain();
    set_entry(0, 'h10, 'h1F, 'h80, 2'b01);
    set_entry(1, 'h18, 'h2F, 'h200, 2'b11);
    set_entry(2, 'h40, 'h4F, 'h300, 2'b00);
    set_entry(3, 'h50, 'h5F, 'hFFFF8, 2'b01);
    cfg_write(32'h100, 32'h1, RESP_SLVERR);
    cfg_read(32'h100, '0, RESP_SLVERR);
    bp_en = 1'b1;
    repeat (200) random_access();
    drain();
    cfg_write(32'h8, 32'h123, RESP_OKAY);
    tbl[0].base_pn = 'h123;
    repeat (60) random_access();
    drain();
    // Every transaction has ended, so the DUT must be quiet
    repeat (5) @(negedge clk_i);
    if (slv_bvalid_o || slv_rvalid_o || mst_awvalid_o || mst_wvalid_o || mst_arvalid_o) begin
      $display("A DUT valid output was still high after all responses returned");
      $display("Regression failed");
      $fatal(1);
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* axi_tlb.f */
hdl/tlb_pkg.sv
hdl/tlb_req_if.sv
hdl/tlb_cfg_regs.sv
hdl/tlb_lookup.sv
hdl/tlb_req_fifo.sv
hdl/tlb_forward.sv
hdl/axi_tlb.sv
dv/tb_axi_tlb_assertions.sv
dv/tb_axi_tlb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the axi_tlb testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axi_tlb \
  -f axi_tlb.f \
  -o Vtb_axi_tlb

./obj_dir/Vtb_axi_tlb | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
